// ==== hw/chan_link_pkg.sv ====
// widths, FIFO depths, thresholds, compensation timing and register map of the channel link
`default_nettype none

package chan_link_pkg;

  // stream payload
  localparam int chan_data_w = 32;            // lane word width
  localparam int chan_keep_w = 4;             // one keep bit per byte

  // FIFOs
  localparam int chan_fifo_depth = 16;        // entries per FIFO
  localparam int chan_fifo_cnt_w = 5;         // holds 0 to depth
  localparam int chan_prog_full  = 12;        // pause threshold, in entries

  // clock compensation
  localparam int cc_period = 64;              // slot start to slot start
  localparam int cc_len    = 4;               // do_cc cycles per slot

  // programming bus and statistics
  localparam int cnt_w      = 32;             // saturating counters
  localparam int stat_n     = 4;              // tx, rx, drop, cc
  localparam int io_addr_w  = 20;             // top bits decoded upstream
  localparam int io_data_w  = 32;
  localparam int loopback_w = 3;              // same width as the transceiver loopback port

  // register word addresses
  localparam logic [io_addr_w-1:0] reg_loopback   = 20'd0;  // rw
  localparam logic [io_addr_w-1:0] reg_status     = 20'd1;  // ro, bit0 channel_up, bit1 pause
  localparam logic [io_addr_w-1:0] reg_tx_count   = 20'd2;  // write clears
  localparam logic [io_addr_w-1:0] reg_rx_count   = 20'd3;
  localparam logic [io_addr_w-1:0] reg_drop_count = 20'd4;
  localparam logic [io_addr_w-1:0] reg_cc_count   = 20'd5;

endpackage

`default_nettype wire

// ==== hw/chan_link_fifo.sv ====
// show-ahead stream FIFO with occupancy count and programmable-full flag
`default_nettype none

module chan_link_fifo (
  input  logic                                  aurora_user_clk,
  input  logic                                  rst_n,
  input  logic                                  s_valid,    // write side
  output logic                                  s_ready,
  input  logic [chan_link_pkg::chan_data_w-1:0] s_data,
  input  logic [chan_link_pkg::chan_keep_w-1:0] s_keep,
  input  logic                                  s_last,
  output logic                                  m_valid,    // read side, head word shown
  input  logic                                  m_ready,
  output logic [chan_link_pkg::chan_data_w-1:0] m_data,
  output logic [chan_link_pkg::chan_keep_w-1:0] m_keep,
  output logic                                  m_last,
  output logic                                  prog_full   // almost full
);
  import chan_link_pkg::*;

  logic [chan_data_w-1:0]     mem_data [chan_fifo_depth];
  logic [chan_keep_w-1:0]     mem_keep [chan_fifo_depth];
  logic                       mem_last [chan_fifo_depth];
  logic [chan_fifo_cnt_w-2:0] wr_ptr;   // wraps at depth
  logic [chan_fifo_cnt_w-2:0] rd_ptr;
  logic [chan_fifo_cnt_w-1:0] count;    // occupancy
  logic                       push;
  logic                       pop;

  assign s_ready   = (count != chan_fifo_depth);  // not full
  assign m_valid   = (count != '0);
  assign push      = s_valid & s_ready;
  assign pop       = m_valid & m_ready;
  assign m_data    = mem_data[rd_ptr];
  assign m_keep    = mem_keep[rd_ptr];
  assign m_last    = mem_last[rd_ptr];
  assign prog_full = (count >= chan_prog_full);   // from registered count

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // idle or simultaneous push and pop
      endcase
    end
  end

  // storage, no reset
  always_ff @(posedge aurora_user_clk) begin
    if (push) begin
      mem_data[wr_ptr] <= s_data;
      mem_keep[wr_ptr] <= s_keep;
      mem_last[wr_ptr] <= s_last;
    end
  end

  a_count_bound: assert property (@(posedge aurora_user_clk) disable iff (!rst_n)
    count <= chan_fifo_depth)
    else $error("fifo occupancy above depth");

  // pointers equal and not full means empty
  a_empty_no_valid: assert property (@(posedge aurora_user_clk) disable iff (!rst_n)
    (wr_ptr == rd_ptr && count != chan_fifo_depth) |-> !m_valid)
    else $error("fifo shows valid while empty");

endmodule

`default_nettype wire

// ==== hw/chan_cc_scheduler.sv ====
// lane_up synchroniser and periodic clock-compensation slot generator
`default_nettype none

module chan_cc_scheduler (
  input  logic aurora_user_clk,
  input  logic rst_n,
  input  logic lane_up,      // level from outside
  output logic channel_up,
  output logic do_cc,        // compensation slot, lane tx idles
  output logic cc_start      // first cycle of each slot
);
  import chan_link_pkg::*;

  logic                         lane_up_r;      // first stage
  logic [$clog2(cc_period)-1:0] cc_cnt;         // cycles into current period
  logic                         period_done;    // at least one full period seen

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_up_r  <= 1'b0;
      channel_up <= 1'b0;
    end else begin
      lane_up_r  <= lane_up;
      channel_up <= lane_up_r;    // two cycles behind lane_up
    end
  end

  // cleared together with channel_up falling, counts while up
  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      cc_cnt      <= '0;
      period_done <= 1'b0;
    end else if (!lane_up_r) begin
      cc_cnt      <= '0;
      period_done <= 1'b0;
    end else if (channel_up) begin
      if (cc_cnt == cc_period - 1) begin
        cc_cnt      <= '0;
        period_done <= 1'b1;
      end else begin
        cc_cnt <= cc_cnt + 1'b1;
      end
    end
  end

  assign do_cc    = period_done & (cc_cnt < cc_len);   // first cc_len cycles after wrap
  assign cc_start = period_done & (cc_cnt == '0);

  a_cc_only_when_up: assert property (@(posedge aurora_user_clk) disable iff (!rst_n)
    do_cc |-> channel_up)
    else $error("do_cc while channel down");

endmodule

`default_nettype wire

// ==== hw/chan_lane_tx.sv ====
// lane transmitter draining the transmit FIFO onto the lane word port
`default_nettype none

module chan_lane_tx (
  input  logic                                  aurora_user_clk,
  input  logic                                  rst_n,
  input  logic                                  channel_up,
  input  logic                                  do_cc,
  input  logic                                  f_valid,        // from tx FIFO
  output logic                                  f_ready,
  input  logic [chan_link_pkg::chan_data_w-1:0] f_data,
  input  logic [chan_link_pkg::chan_keep_w-1:0] f_keep,
  input  logic                                  f_last,
  output logic                                  lane_tx_valid,  // no ready on the lane
  output logic [chan_link_pkg::chan_data_w-1:0] lane_tx_data,
  output logic [chan_link_pkg::chan_keep_w-1:0] lane_tx_keep,
  output logic                                  lane_tx_last,
  output logic                                  tx_beat         // one per word sent
);
  import chan_link_pkg::*;

  logic accept;

  assign f_ready = channel_up & ~do_cc;   // open slot only
  assign accept  = f_valid & f_ready;

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_tx_valid <= 1'b0;
    end else begin
      lane_tx_valid <= accept;            // idle otherwise
    end
  end

  always_ff @(posedge aurora_user_clk) begin
    if (accept) begin
      lane_tx_data <= f_data;
      lane_tx_keep <= f_keep;
      lane_tx_last <= f_last;
    end
  end

  assign tx_beat = lane_tx_valid;

endmodule

`default_nettype wire

// ==== hw/chan_lane_rx.sv ====
// lane receiver with loopback select, one register stage and drop on full receive FIFO
`default_nettype none

module chan_lane_rx (
  input  logic                                  aurora_user_clk,
  input  logic                                  rst_n,
  input  logic [chan_link_pkg::loopback_w-1:0]  loopback_set,   // nonzero picks loopback
  input  logic                                  lane_rx_valid,
  input  logic [chan_link_pkg::chan_data_w-1:0] lane_rx_data,
  input  logic [chan_link_pkg::chan_keep_w-1:0] lane_rx_keep,
  input  logic                                  lane_rx_last,
  input  logic                                  lb_valid,       // near-end loopback
  input  logic [chan_link_pkg::chan_data_w-1:0] lb_data,
  input  logic [chan_link_pkg::chan_keep_w-1:0] lb_keep,
  input  logic                                  lb_last,
  input  logic                                  fifo_full,
  output logic                                  w_valid,        // rx FIFO write
  output logic [chan_link_pkg::chan_data_w-1:0] w_data,
  output logic [chan_link_pkg::chan_keep_w-1:0] w_keep,
  output logic                                  w_last,
  output logic                                  rx_beat,
  output logic                                  drop_pulse
);
  import chan_link_pkg::*;

  logic use_lb;
  logic held_valid;   // word in the stage

  assign use_lb = (loopback_set != '0);

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
    end else begin
      held_valid <= use_lb ? lb_valid : lane_rx_valid;
    end
  end

  always_ff @(posedge aurora_user_clk) begin
    w_data <= use_lb ? lb_data : lane_rx_data;
    w_keep <= use_lb ? lb_keep : lane_rx_keep;
    w_last <= use_lb ? lb_last : lane_rx_last;
  end

  // no back-pressure upstream, so a full FIFO loses the word
  assign w_valid    = held_valid & ~fifo_full;
  assign drop_pulse = held_valid & fifo_full;
  assign rx_beat    = w_valid;

  // each source word leaves the stage one cycle later, as a write or as a drop
  a_word_written_or_dropped: assert property (@(posedge aurora_user_clk) disable iff (!rst_n)
    (use_lb ? lb_valid : lane_rx_valid) |=> (w_valid ^ drop_pulse))
    else $error("lane word neither written nor dropped one cycle later");

endmodule

`default_nettype wire

// ==== hw/chan_io_block.sv ====
// programming-bus registers for loopback, link status and statistics counters
`default_nettype none

module chan_io_block (
  input  logic                                 aurora_user_clk,
  input  logic                                 rst_n,
  input  logic                                 io_sel,        // block selected
  input  logic                                 io_sync,       // transfer start
  input  logic [chan_link_pkg::io_addr_w-1:0]  io_addr,
  input  logic                                 io_rd_en,
  input  logic                                 io_wr_en,
  input  logic [chan_link_pkg::io_data_w-1:0]  io_wr_data,
  input  logic                                 channel_up,
  input  logic                                 acq_readout_pause,
  input  logic                                 tx_beat,
  input  logic                                 rx_beat,
  input  logic                                 drop_pulse,
  input  logic                                 cc_start,
  output logic [chan_link_pkg::io_data_w-1:0]  io_rd_data,
  output logic                                 io_rd_ack,     // one cycle after the read
  output logic [chan_link_pkg::loopback_w-1:0] loopback_set
);
  import chan_link_pkg::*;

  logic                        wr_stb;
  logic                        rd_stb;
  logic [stat_n-1:0]           stat_evt;   // tx, rx, drop, cc
  logic [stat_n-1:0][cnt_w-1:0] stat_cnt;
  logic [io_data_w-1:0]        rd_value;

  assign wr_stb   = io_sel & io_sync & io_wr_en;
  assign rd_stb   = io_sel & io_sync & io_rd_en;
  assign stat_evt = {cc_start, drop_pulse, rx_beat, tx_beat};   // order of reg_tx_count on

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      loopback_set <= '0;
    end else if (wr_stb && io_addr == reg_loopback) begin
      loopback_set <= io_wr_data[loopback_w-1:0];
    end
  end

  // saturating counters, a write to one clears it
  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      stat_cnt <= '0;
    end else begin
      for (int i = 0; i < stat_n; i++) begin
        if (wr_stb && io_addr == reg_tx_count + i) begin
          stat_cnt[i] <= '0;
        end else if (stat_evt[i] && stat_cnt[i] != '1) begin
          stat_cnt[i] <= stat_cnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_value = '0;                       // undefined address
    case (io_addr)
      reg_loopback:   rd_value = io_data_w'(loopback_set);
      reg_status:     rd_value = io_data_w'({acq_readout_pause, channel_up});
      reg_tx_count:   rd_value = io_data_w'(stat_cnt[0]);
      reg_rx_count:   rd_value = io_data_w'(stat_cnt[1]);
      reg_drop_count: rd_value = io_data_w'(stat_cnt[2]);
      reg_cc_count:   rd_value = io_data_w'(stat_cnt[3]);
      default:        rd_value = '0;
    endcase
  end

  always_ff @(posedge aurora_user_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_rd_ack <= 1'b0;
    end else begin
      io_rd_ack <= rd_stb;
    end
  end

  always_ff @(posedge aurora_user_clk) begin
    if (rd_stb) io_rd_data <= rd_value;   // held until next read
  end

endmodule

`default_nettype wire

// ==== hw/one_channel.sv ====
// channel link top with transmit and receive FIFOs, compensation scheduler, lane tx/rx and registers
`default_nettype none

module one_channel (
  input  logic                                  aurora_user_clk,
  input  logic                                  rst_n,
  input  logic                                  lane_up,            // from the lane side
  // stream into the transmit FIFO
  input  logic                                  s_axis_tx_tvalid,
  output logic                                  s_axis_tx_tready,
  input  logic [chan_link_pkg::chan_data_w-1:0] s_axis_tx_tdata,
  input  logic [chan_link_pkg::chan_keep_w-1:0] s_axis_tx_tkeep,
  input  logic                                  s_axis_tx_tlast,
  // stream out of the receive FIFO
  output logic                                  m_axis_rx_tvalid,
  input  logic                                  m_axis_rx_tready,
  output logic [chan_link_pkg::chan_data_w-1:0] m_axis_rx_tdata,
  output logic [chan_link_pkg::chan_keep_w-1:0] m_axis_rx_tkeep,
  output logic                                  m_axis_rx_tlast,
  // parallel lane word ports
  output logic                                  lane_tx_valid,
  output logic [chan_link_pkg::chan_data_w-1:0] lane_tx_data,
  output logic [chan_link_pkg::chan_keep_w-1:0] lane_tx_keep,
  output logic                                  lane_tx_last,
  input  logic                                  lane_rx_valid,
  input  logic [chan_link_pkg::chan_data_w-1:0] lane_rx_data,
  input  logic [chan_link_pkg::chan_keep_w-1:0] lane_rx_keep,
  input  logic                                  lane_rx_last,
  output logic                                  acq_readout_pause,  // rx FIFO almost full
  // programming bus
  input  logic                                  io_sel,
  input  logic                                  io_sync,
  input  logic [chan_link_pkg::io_addr_w-1:0]   io_addr,
  input  logic                                  io_rd_en,
  input  logic                                  io_wr_en,
  input  logic [chan_link_pkg::io_data_w-1:0]   io_wr_data,
  output logic [chan_link_pkg::io_data_w-1:0]   io_rd_data,
  output logic                                  io_rd_ack
);
  import chan_link_pkg::*;

  logic                   channel_up, do_cc, cc_start;
  logic                   tx_s_ready;                  // tx FIFO not full
  logic                   tx_f_valid, tx_f_ready, tx_f_last;
  logic [chan_data_w-1:0] tx_f_data;
  logic [chan_keep_w-1:0] tx_f_keep;
  logic                   rx_s_ready;                  // rx FIFO not full
  logic                   rx_w_valid, rx_w_last;
  logic [chan_data_w-1:0] rx_w_data;
  logic [chan_keep_w-1:0] rx_w_keep;
  logic                   tx_beat, rx_beat, drop_pulse;
  logic [loopback_w-1:0]  loopback_set;

  // input stream held off until the channel is up
  assign s_axis_tx_tready = tx_s_ready & channel_up;

  chan_link_fifo u_tx_fifo (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n),
    .s_valid(s_axis_tx_tvalid & channel_up), .s_ready(tx_s_ready),
    .s_data(s_axis_tx_tdata), .s_keep(s_axis_tx_tkeep), .s_last(s_axis_tx_tlast),
    .m_valid(tx_f_valid), .m_ready(tx_f_ready),
    .m_data(tx_f_data), .m_keep(tx_f_keep), .m_last(tx_f_last),
    .prog_full()                                        // no pause on the tx side
  );

  chan_cc_scheduler u_cc_scheduler (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n), .lane_up(lane_up),
    .channel_up(channel_up), .do_cc(do_cc), .cc_start(cc_start)
  );

  chan_lane_tx u_lane_tx (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n),
    .channel_up(channel_up), .do_cc(do_cc),
    .f_valid(tx_f_valid), .f_ready(tx_f_ready),
    .f_data(tx_f_data), .f_keep(tx_f_keep), .f_last(tx_f_last),
    .lane_tx_valid(lane_tx_valid), .lane_tx_data(lane_tx_data),
    .lane_tx_keep(lane_tx_keep), .lane_tx_last(lane_tx_last),
    .tx_beat(tx_beat)
  );

  chan_lane_rx u_lane_rx (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n), .loopback_set(loopback_set),
    .lane_rx_valid(lane_rx_valid), .lane_rx_data(lane_rx_data),
    .lane_rx_keep(lane_rx_keep), .lane_rx_last(lane_rx_last),
    .lb_valid(lane_tx_valid), .lb_data(lane_tx_data),   // near-end loopback
    .lb_keep(lane_tx_keep), .lb_last(lane_tx_last),
    .fifo_full(~rx_s_ready),
    .w_valid(rx_w_valid), .w_data(rx_w_data), .w_keep(rx_w_keep), .w_last(rx_w_last),
    .rx_beat(rx_beat), .drop_pulse(drop_pulse)
  );

  chan_link_fifo u_rx_fifo (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n),
    .s_valid(rx_w_valid), .s_ready(rx_s_ready),
    .s_data(rx_w_data), .s_keep(rx_w_keep), .s_last(rx_w_last),
    .m_valid(m_axis_rx_tvalid), .m_ready(m_axis_rx_tready),
    .m_data(m_axis_rx_tdata), .m_keep(m_axis_rx_tkeep), .m_last(m_axis_rx_tlast),
    .prog_full(acq_readout_pause)
  );

  chan_io_block u_io_block (
    .aurora_user_clk(aurora_user_clk), .rst_n(rst_n),
    .io_sel(io_sel), .io_sync(io_sync), .io_addr(io_addr),
    .io_rd_en(io_rd_en), .io_wr_en(io_wr_en), .io_wr_data(io_wr_data),
    .channel_up(channel_up), .acq_readout_pause(acq_readout_pause),
    .tx_beat(tx_beat), .rx_beat(rx_beat), .drop_pulse(drop_pulse), .cc_start(cc_start),
    .io_rd_data(io_rd_data), .io_rd_ack(io_rd_ack), .loopback_set(loopback_set)
  );

endmodule

`default_nettype wire

// ==== dv/tb_one_channel.sv ====
// testbench for one_channel with clock, reset, bus and stream tasks, directed tests and a closing report
`default_nettype none

module tb_one_channel;
  timeunit 1ns;
  timeprecision 100ps;
  import chan_link_pkg::*;

  typedef logic [chan_data_w+chan_keep_w:0] beat_t;   // {last, keep, data}

  logic                   aurora_user_clk, rst_n, lane_up;
  logic                   s_axis_tx_tvalid, s_axis_tx_tready, s_axis_tx_tlast;
  logic [chan_data_w-1:0] s_axis_tx_tdata, m_axis_rx_tdata, lane_tx_data, lane_rx_data;
  logic [chan_keep_w-1:0] s_axis_tx_tkeep, m_axis_rx_tkeep, lane_tx_keep, lane_rx_keep;
  logic                   m_axis_rx_tvalid, m_axis_rx_tready, m_axis_rx_tlast;
  logic                   lane_tx_valid, lane_tx_last, lane_rx_valid, lane_rx_last;
  logic                   acq_readout_pause, io_sel, io_sync, io_rd_en, io_wr_en, io_rd_ack;
  logic [io_addr_w-1:0]   io_addr;
  logic [io_data_w-1:0]   io_wr_data, io_rd_data;
  int                     errors = 0;
  int                     tests_run = 0;
  beat_t                  lane_q[$];   // words seen on lane_tx
  beat_t                  exp_q[$];    // expected words, in order

  one_channel u_one_channel (.*);

  always #50 aurora_user_clk = ~aurora_user_clk;   // 100 ns period

  // lane output sampled mid-cycle, away from the edge
  always @(negedge aurora_user_clk) begin
    if (rst_n && lane_tx_valid) lane_q.push_back({lane_tx_last, lane_tx_keep, lane_tx_data});
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  function automatic beat_t make_beat(input bit last);
    return {last, chan_keep_w'($urandom_range(15, 1)), chan_data_w'($urandom)};
  endfunction

  task automatic tick;   // next edge, then the drive point
    @(posedge aurora_user_clk);
    #1;
  endtask

  task automatic bus_write(input logic [io_addr_w-1:0] addr, input logic [io_data_w-1:0] data);
    io_sel = 1'b1;
    io_sync = 1'b1;
    io_wr_en = 1'b1;
    io_addr = addr;
    io_wr_data = data;
    tick();
    io_sel = 1'b0;
    io_sync = 1'b0;
    io_wr_en = 1'b0;
  endtask

  task automatic bus_read(input logic [io_addr_w-1:0] addr, output logic [io_data_w-1:0] data);
    int n;
    io_sel = 1'b1;
    io_sync = 1'b1;
    io_rd_en = 1'b1;
    io_addr = addr;
    tick();
    io_sel = 1'b0;
    io_sync = 1'b0;
    io_rd_en = 1'b0;
    n = 0;
    while (!io_rd_ack && n < 8) begin
      tick();
      n++;
    end
    if (!io_rd_ack) begin
      report_failure("no read acknowledge from the register block");
      data = '0;
    end else begin
      if (n != 0) report_failure("read acknowledge came later than the next cycle");
      data = io_rd_data;
      tick();
      if (io_rd_ack !== 1'b0) report_mismatch("io_rd_ack", io_rd_ack, 0);   // one cycle only
    end
  endtask

  task automatic check_reg(input string name, input logic [io_addr_w-1:0] addr,
                           input logic [io_data_w-1:0] exp);
    logic [io_data_w-1:0] v;
    bus_read(addr, v);
    if (v !== exp) report_mismatch(name, v, exp);
  endtask

  task automatic send_beat(input beat_t b);
    int n;
    s_axis_tx_tvalid = 1'b1;
    {s_axis_tx_tlast, s_axis_tx_tkeep, s_axis_tx_tdata} = b;
    n = 0;
    while (!s_axis_tx_tready && n < 200) begin   // ready is registered state
      tick();
      n++;
    end
    if (!s_axis_tx_tready) report_failure("transmit stream never accepted a word");
    tick();
    s_axis_tx_tvalid = 1'b0;
  endtask

  task automatic recv_beat(output beat_t b);
    int n;
    m_axis_rx_tready = 1'b1;
    n = 0;
    while (!m_axis_rx_tvalid && n < 300) begin
      tick();
      n++;
    end
    if (!m_axis_rx_tvalid) report_failure("receive stream produced no word");
    b = {m_axis_rx_tlast, m_axis_rx_tkeep, m_axis_rx_tdata};   // popped at the next edge
    tick();
    m_axis_rx_tready = 1'b0;
  endtask

  task automatic drive_lane_rx(input beat_t b);
    lane_rx_valid = 1'b1;
    {lane_rx_last, lane_rx_keep, lane_rx_data} = b;
    tick();
    lane_rx_valid = 1'b0;
  endtask

  task automatic wait_lane_count(input int count);
    int n;
    n = 0;
    while (lane_q.size() < count && n < 500) begin
      tick();
      n++;
    end
    if (lane_q.size() < count) report_failure("too few words on lane_tx");
  endtask

  task automatic wait_lane_idle;
    int n, quiet;
    n = 0;
    quiet = 0;
    while (quiet < 2 * cc_len && n < 500) begin   // longer than one compensation gap
      quiet = lane_tx_valid ? 0 : quiet + 1;
      tick();
      n++;
    end
    if (quiet < 2 * cc_len) report_failure("lane_tx never went idle");
  endtask

  task automatic test_reset_state;
    if (s_axis_tx_tready !== 1'b0) report_mismatch("s_axis_tx_tready", s_axis_tx_tready, 0);
    if (lane_tx_valid !== 1'b0) report_mismatch("lane_tx_valid", lane_tx_valid, 0);
    if (m_axis_rx_tvalid !== 1'b0) report_mismatch("m_axis_rx_tvalid", m_axis_rx_tvalid, 0);
    if (acq_readout_pause !== 1'b0) report_mismatch("acq_readout_pause", acq_readout_pause, 0);
    if (io_rd_ack !== 1'b0) report_mismatch("io_rd_ack", io_rd_ack, 0);
    check_reg("loopback", reg_loopback, 0);
    check_reg("tx_count", reg_tx_count, 0);
    check_reg("rx_count", reg_rx_count, 0);
    check_reg("drop_count", reg_drop_count, 0);
    check_reg("cc_count", reg_cc_count, 0);
  endtask

  task automatic test_loopback;
    beat_t b;
    lane_up = 1'b1;
    bus_write(reg_loopback, 1);
    exp_q.delete();
    for (int i = 0; i < 8; i++) begin
      b = make_beat(i == 7);            // frame ends on word 8
      exp_q.push_back(b);
      send_beat(b);
    end
    for (int i = 0; i < 8; i++) begin
      recv_beat(b);
      if (b !== exp_q[i]) report_mismatch("m_axis_rx {tlast,tkeep,tdata}", b, exp_q[i]);
    end
    check_reg("tx_count", reg_tx_count, 8);
    check_reg("rx_count", reg_rx_count, 8);
  endtask

  task automatic test_lane_path;
    beat_t b;
    bus_write(reg_loopback, 0);
    lane_q.delete();
    exp_q.delete();
    for (int i = 0; i < 6; i++) begin
      b = make_beat(i == 5);
      exp_q.push_back(b);
      send_beat(b);
    end
    wait_lane_count(6);
    for (int i = 0; i < 6; i++) begin
      if (lane_q[i] !== exp_q[i])
        report_mismatch("lane_tx {last,keep,data}", lane_q[i], exp_q[i]);
    end
    exp_q.delete();
    for (int i = 0; i < 6; i++) begin
      b = make_beat(i == 5);
      exp_q.push_back(b);
      drive_lane_rx(b);                 // back to back, no ready on the lane
    end
    for (int i = 0; i < 6; i++) begin
      recv_beat(b);
      if (b !== exp_q[i]) report_mismatch("m_axis_rx {tlast,tkeep,tdata}", b, exp_q[i]);
    end
  endtask

  task automatic test_compensation;
    logic [io_data_w-1:0] cc_before, cc_after;
    int run, max_run;
    bit taken;
    run = 0;
    max_run = 0;
    bus_read(reg_cc_count, cc_before);
    {s_axis_tx_tlast, s_axis_tx_tkeep, s_axis_tx_tdata} = make_beat(1'b0);
    s_axis_tx_tvalid = 1'b1;           // offer a word every cycle
    for (int i = 0; i < 10 * cc_period; i++) begin
      taken = s_axis_tx_tready;
      run = lane_tx_valid ? run + 1 : 0;
      if (run > max_run) max_run = run;
      tick();
      if (taken) {s_axis_tx_tlast, s_axis_tx_tkeep, s_axis_tx_tdata} = make_beat(1'b0);
    end
    s_axis_tx_tvalid = 1'b0;
    bus_read(reg_cc_count, cc_after);
    if (cc_after - cc_before < 9 || cc_after - cc_before > 11)
      report_mismatch("cc_count delta", cc_after - cc_before, 10);
    if (max_run > cc_period - cc_len)
      report_failure($sformatf("lane_tx_valid high for %0d cycles in a row", max_run));
    wait_lane_idle();
    lane_q.delete();
  endtask

  task automatic test_overflow;
    beat_t b;
    bus_write(reg_drop_count, 0);
    exp_q.delete();
    for (int i = 0; i < 20; i++) begin
      b = make_beat(i == 19);
      exp_q.push_back(b);
      drive_lane_rx(b);                 // m_axis_rx_tready stays low
      if (acq_readout_pause !== (i >= chan_prog_full))   // occupancy is i here, capped at depth
        report_mismatch("acq_readout_pause", acq_readout_pause, i >= chan_prog_full);
    end
    tick();                             // receiver stage, then the last drop
    tick();
    if (acq_readout_pause !== 1'b1) report_mismatch("acq_readout_pause", acq_readout_pause, 1);
    check_reg("drop_count", reg_drop_count, 4);
    for (int i = 0; i < chan_fifo_depth; i++) begin
      recv_beat(b);
      if (b !== exp_q[i]) report_mismatch("m_axis_rx {tlast,tkeep,tdata}", b, exp_q[i]);
    end
    if (m_axis_rx_tvalid !== 1'b0) report_mismatch("m_axis_rx_tvalid", m_axis_rx_tvalid, 0);
    if (acq_readout_pause !== 1'b0) report_mismatch("acq_readout_pause", acq_readout_pause, 0);
  endtask

  task automatic test_channel_down;
    logic [io_data_w-1:0] st;
    int n;
    lane_up = 1'b0;
    st = 1;
    n = 0;
    while (st[0] && n < 10) begin
      bus_read(reg_status, st);
      n++;
    end
    if (st[0] !== 1'b0) report_mismatch("status channel_up", st[0], 0);
    lane_q.delete();
    exp_q.delete();
    for (int i = 0; i < 4; i++) exp_q.push_back(make_beat(i == 3));
    s_axis_tx_tvalid = 1'b1;           // held while down
    {s_axis_tx_tlast, s_axis_tx_tkeep, s_axis_tx_tdata} = exp_q[0];
    for (int i = 0; i < 20; i++) begin
      if (s_axis_tx_tready !== 1'b0) report_mismatch("s_axis_tx_tready", s_axis_tx_tready, 0);
      tick();
    end
    if (lane_q.size() != 0) report_failure("words reached lane_tx while the channel was down");
    lane_up = 1'b1;
    for (int i = 0; i < 4; i++) send_beat(exp_q[i]);
    wait_lane_count(4);
    for (int i = 0; i < 4; i++) begin
      if (lane_q[i] !== exp_q[i])
        report_mismatch("lane_tx {last,keep,data}", lane_q[i], exp_q[i]);
    end
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(32'hab9e_3838);
    aurora_user_clk = 1'b0;
    rst_n = 1'b0;
    lane_up = 1'b0;
    s_axis_tx_tvalid = 1'b0;
    s_axis_tx_tdata = '0;
    s_axis_tx_tkeep = '0;
    s_axis_tx_tlast = 1'b0;
    m_axis_rx_tready = 1'b0;
    lane_rx_valid = 1'b0;
    lane_rx_data = '0;
    lane_rx_keep = '0;
    lane_rx_last = 1'b0;
    io_sel = 1'b0;
    io_sync = 1'b0;
    io_rd_en = 1'b0;
    io_wr_en = 1'b0;
    io_addr = '0;
    io_wr_data = '0;
    repeat (5) @(posedge aurora_user_clk);
    #1 rst_n = 1'b1;
    tick();
    test_reset_state();
    tests_run++;
    test_loopback();
    tests_run++;
    test_lane_path();
    tests_run++;
    test_compensation();
    tests_run++;
    test_overflow();
    tests_run++;
    test_channel_down();
    tests_run++;
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/chan_link_pkg.sv
hw/chan_link_fifo.sv
hw/chan_cc_scheduler.sv
hw/chan_lane_tx.sv
hw/chan_lane_rx.sv
hw/chan_io_block.sv
hw/one_channel.sv
dv/tb_one_channel.sv
